// ==== flit_crossbar.sv ====
`include "noc_defs.svh"

module flit_crossbar (
        input  logic                                    clk,
        input  logic                                    arst_n_i,
        input  noc_dir_pkg::port_vec_t [`NUM_PORTS-1:0] grant_i,     // per output, one-hot
        input  noc_flit_pkg::flit_t [`NUM_PORTS-1:0]    flit_i,
        output noc_dir_pkg::port_vec_t                  out_valid_o,
        output noc_flit_pkg::flit_t [`NUM_PORTS-1:0]    out_flit_o
);
        import noc_dir_pkg::*;
        import noc_flit_pkg::*;

        flit_t [`NUM_PORTS-1:0] sel_flit;
        port_vec_t              any_gnt;

        // and-or mux, grants are one-hot so at most one term survives
        always_comb begin
                sel_flit = '0;
                for (int o = 0; o < `NUM_PORTS; o++) begin
                        any_gnt[o] = |grant_i[o];
                        for (int i = 0; i < `NUM_PORTS; i++) begin
                                sel_flit[o] = sel_flit[o] | (flit_i[i] & {`FLIT_W{grant_i[o][i]}});
                        end
                end
        end

        always_ff @(posedge clk or negedge arst_n_i) begin
                if (!arst_n_i) begin
                        out_valid_o <= '0;
                        out_flit_o  <= '0;
                end else begin
                        out_valid_o <= any_gnt;         // clears when no grant
                        for (int o = 0; o < `NUM_PORTS; o++) begin
                                if (any_gnt[o]) begin
                                        out_flit_o[o] <= sel_flit[o];
                                end
                        end
                end
        end

endmodule

// ==== noc_defs.svh ====
`ifndef NOC_DEFS_SVH
`define NOC_DEFS_SVH

// flit payload width
`define FLIT_W 16

// direction code width, codes 5..7 unused
`define DIR_W 3

// n, s, w, e, l
`define NUM_PORTS 5

`endif

// ==== noc_dir_pkg.sv ====
`include "noc_defs.svh"

package noc_dir_pkg;

        typedef logic [`DIR_W-1:0] dir_t;               // next-hop / output direction code

        // one bit per router port, indexed by direction code
        typedef logic [`NUM_PORTS-1:0] port_vec_t;

        localparam dir_t DIR_N = dir_t'(0);
        localparam dir_t DIR_S = dir_t'(1);
        localparam dir_t DIR_W = dir_t'(2);
        localparam dir_t DIR_E = dir_t'(3);
        localparam dir_t DIR_L = dir_t'(4);             // local port, highest code

endpackage

// ==== noc_flit_pkg.sv ====
`include "noc_defs.svh"

package noc_flit_pkg;

        typedef logic [`FLIT_W-1:0] flit_t;             // flit payload

        // one bit per candidate input of an arbiter
        // every port except the guarded output itself
        typedef logic [`NUM_PORTS-2:0] cand_vec_t;

endpackage

// ==== route_comparator.sv ====
`include "noc_defs.svh"

module route_comparator #(
        parameter noc_dir_pkg::dir_t OUT_DIR = noc_dir_pkg::DIR_E
) (
        input  noc_dir_pkg::port_vec_t             in_valid_i,
        input  noc_dir_pkg::dir_t [`NUM_PORTS-1:0] nexthop_i,
        output noc_flit_pkg::cand_vec_t            req_o
);
        import noc_dir_pkg::*;

        // candidate slots are the other four directions, ascending code order
        for (genvar k = 0; k < `NUM_PORTS - 1; k++) begin : g_cand
                // skip over the guarded direction
                localparam dir_t CAND_DIR = (k < OUT_DIR) ? dir_t'(k) : dir_t'(k + 1);

                // unused codes 5..7 never equal a real OUT_DIR
                assign req_o[k] = in_valid_i[CAND_DIR] && (nexthop_i[CAND_DIR] == OUT_DIR);
        end

endmodule

// ==== rr_priority_enc.sv ====
module rr_priority_enc (
        input  noc_flit_pkg::cand_vec_t req_i,
        input  noc_flit_pkg::cand_vec_t ptr_i,     // one-hot, slot with highest priority
        output noc_flit_pkg::cand_vec_t gnt_o,
        output logic                    any_gnt_o
);
        import noc_flit_pkg::*;

        localparam int N = $bits(cand_vec_t);

        logic [2*N-1:0] req_dbl;
        logic [2*N-1:0] ptr_ext;
        logic [2*N-1:0] gnt_dbl;

        // requests twice side by side so the search wraps around
        assign req_dbl = {req_i, req_i};
        assign ptr_ext = {{N{1'b0}}, ptr_i};

        // borrow ripples up from the pointer and stops at the first request
        // at or above it, that bit is the only one left set by the mask
        assign gnt_dbl = req_dbl & ~(req_dbl - ptr_ext);

        // fold upper half back onto the slots
        assign gnt_o = gnt_dbl[N-1:0] | gnt_dbl[2*N-1:N];

        assign any_gnt_o = |gnt_o;                 // to pointer update

endmodule

// ==== rr_processor.sv ====
`include "noc_defs.svh"

module rr_processor #(
        parameter noc_dir_pkg::dir_t OUT_DIR = noc_dir_pkg::DIR_E
) (
        input  logic                               clk,
        input  logic                               arst_n_i,
        input  noc_dir_pkg::port_vec_t             in_valid_i,
        input  noc_dir_pkg::dir_t [`NUM_PORTS-1:0] nexthop_i,
        output noc_dir_pkg::port_vec_t             grant_o
);
        import noc_flit_pkg::*;

        localparam int N_CAND = $bits(cand_vec_t);

        cand_vec_t req;
        cand_vec_t ptr_q;
        cand_vec_t gnt;
        logic      any_gnt;

        route_comparator #(
                .OUT_DIR    (OUT_DIR)
        ) u_route_comparator (
                .in_valid_i (in_valid_i),
                .nexthop_i  (nexthop_i),
                .req_o      (req)
        );

        rr_priority_enc u_rr_priority_enc (
                .req_i      (req),
                .ptr_i      (ptr_q),
                .gnt_o      (gnt),
                .any_gnt_o  (any_gnt)
        );

        // pointer moves to the slot after the winner, holds when idle
        always_ff @(posedge clk or negedge arst_n_i) begin
                if (!arst_n_i) begin
                        ptr_q <= cand_vec_t'(1);
                end else if (any_gnt) begin
                        ptr_q <= {gnt[N_CAND-2:0], gnt[N_CAND-1]};   // rotate left
                end
        end

        // slots back onto port bits, own direction is a hole
        for (genvar d = 0; d < `NUM_PORTS; d++) begin : g_spread
                if (d < OUT_DIR) begin : g_below
                        assign grant_o[d] = gnt[d];
                end else if (d == OUT_DIR) begin : g_self
                        assign grant_o[d] = 1'b0;
                end else begin : g_above
                        assign grant_o[d] = gnt[d-1];
                end
        end

endmodule

// ==== switch_alloc.f ====
+incdir+.
noc_dir_pkg.sv
noc_flit_pkg.sv
route_comparator.sv
rr_priority_enc.sv
rr_processor.sv
flit_crossbar.sv
switch_alloc_top.sv
switch_alloc_tb.sv

// ==== switch_alloc_tb.sv ====
`include "noc_defs.svh"

module switch_alloc_tb;
        import noc_dir_pkg::*;
        import noc_flit_pkg::*;

        localparam int NP       = `NUM_PORTS;
        localparam int N_CAND   = NP - 1;
        localparam int N_FIXED  = 12;
        localparam int N_RAND   = 40;
        localparam int TBL_LEN  = N_FIXED + N_RAND;
        localparam int WATCHDOG = (TBL_LEN + 10) * 4;

        logic                  clk;
        logic                  arst_n;
        port_vec_t             in_valid;
        dir_t [NP-1:0]         nexthop;
        flit_t [NP-1:0]        flit_in;
        port_vec_t [NP-1:0]    out_grant;
        port_vec_t             out_valid;
        flit_t [NP-1:0]        out_flit;

        // one row per cycle, grants indexed by output
        port_vec_t             tbl_valid [TBL_LEN];
        dir_t [NP-1:0]         tbl_hop   [TBL_LEN];
        flit_t [NP-1:0]        tbl_flit  [TBL_LEN];
        port_vec_t [NP-1:0]    tbl_gnt   [TBL_LEN];

        int                    mdl_ptr [NP];           // candidate slot with top priority
        port_vec_t             exp_valid;
        flit_t [NP-1:0]        exp_flit;
        int unsigned           seed_ret;

        switch_alloc_top u_switch_alloc_top (
                .clk         (clk),
                .arst_n_i    (arst_n),
                .in_valid_i  (in_valid),
                .nexthop_i   (nexthop),
                .flit_i      (flit_in),
                .out_grant_o (out_grant),
                .out_valid_o (out_valid),
                .out_flit_o  (out_flit)
        );

        initial begin
                clk = 1'b0;
                forever #2 clk = ~clk;
        end

        initial begin
                #(WATCHDOG);
                $display("watchdog expired, the run did not finish in time");
                $display("Test failed");
                $fatal(1, "timeout");
        end

        task automatic check_grant(input string name, input port_vec_t exp, input port_vec_t act);
                if (act !== exp) begin
                        $display("** Error at %0t: %s expected %b, got %b", $time, name, exp, act);
                        $display("Test failed");
                        $fatal(1, "mismatch on %s", name);
                end
        endtask

        task automatic check_flit(input string name, input flit_t exp, input flit_t act);
                if (act !== exp) begin
                        $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
                        $display("Test failed");
                        $fatal(1, "mismatch on %s", name);
                end
        endtask

        // round-robin rule: first request at or after the pointer, pointer goes past winner
        function automatic port_vec_t model_grant(input int o, input port_vec_t v,
                                                  input dir_t [NP-1:0] hop);
                port_vec_t g;
                int        k;
                int        d;
                g = '0;
                for (int i = 0; i < N_CAND; i++) begin
                        k = (mdl_ptr[o] + i) % N_CAND;
                        d = (k < o) ? k : k + 1;        // slots skip the output itself
                        if (v[d] && hop[d] == dir_t'(o)) begin
                                g[d]       = 1'b1;
                                mdl_ptr[o] = (k + 1) % N_CAND;
                                break;
                        end
                end
                return g;
        endfunction

        task automatic put_fixed(input int e, input port_vec_t v, input dir_t [NP-1:0] hop,
                                 input port_vec_t [NP-1:0] gnt);
                tbl_valid[e] = v;
                tbl_hop[e]   = hop;
                tbl_gnt[e]   = gnt;
                for (int i = 0; i < NP; i++) begin
                        tbl_flit[e][i] = flit_t'(16'ha000 | (e << 4) | i);
                end
        endtask

        task automatic build_table();
                port_vec_t g;
                // hop and grant rows read {L, E, W, S, N}
                put_fixed(0, '0, '0, '0);
                put_fixed(1, 5'b10000, {DIR_E, DIR_N, DIR_N, DIR_N, DIR_N},
                          {5'b0, 5'b10000, 5'b0, 5'b0, 5'b0});
                put_fixed(2, '0, '0, '0);
                // all four east candidates, held for four cycles
                put_fixed(3, 5'b10111, {DIR_E, DIR_N, DIR_E, DIR_E, DIR_E},
                          {5'b0, 5'b00001, 5'b0, 5'b0, 5'b0});
                put_fixed(4, 5'b10111, {DIR_E, DIR_N, DIR_E, DIR_E, DIR_E},
                          {5'b0, 5'b00010, 5'b0, 5'b0, 5'b0});
                put_fixed(5, 5'b10111, {DIR_E, DIR_N, DIR_E, DIR_E, DIR_E},
                          {5'b0, 5'b00100, 5'b0, 5'b0, 5'b0});
                put_fixed(6, 5'b10111, {DIR_E, DIR_N, DIR_E, DIR_E, DIR_E},
                          {5'b0, 5'b10000, 5'b0, 5'b0, 5'b0});
                // sparse, pointer at 0 then 3 then 1
                put_fixed(7, 5'b10100, {DIR_E, DIR_N, DIR_E, DIR_N, DIR_N},
                          {5'b0, 5'b00100, 5'b0, 5'b0, 5'b0});
                put_fixed(8, 5'b00101, {DIR_N, DIR_N, DIR_E, DIR_N, DIR_E},
                          {5'b0, 5'b00001, 5'b0, 5'b0, 5'b0});
                put_fixed(9, 5'b00101, {DIR_N, DIR_N, DIR_E, DIR_N, DIR_E},
                          {5'b0, 5'b00100, 5'b0, 5'b0, 5'b0});
                // east asks for itself, local uses an unused code
                put_fixed(10, 5'b11111, {dir_t'(5), DIR_E, DIR_E, DIR_N, DIR_S},
                          {5'b0, 5'b00100, 5'b0, 5'b00001, 5'b00010});
                put_fixed(11, '0, '0, '0);

                for (int o = 0; o < NP; o++) begin
                        mdl_ptr[o] = 0;
                end
                for (int e = 0; e < TBL_LEN; e++) begin
                        if (e >= N_FIXED) begin
                                tbl_valid[e] = port_vec_t'($urandom);
                                for (int i = 0; i < NP; i++) begin
                                        tbl_hop[e][i]  = dir_t'($urandom_range(5, 0));
                                        tbl_flit[e][i] = flit_t'($urandom);
                                end
                        end
                        // model runs over fixed rows too, keeps pointers in step
                        for (int o = 0; o < NP; o++) begin
                                g = model_grant(o, tbl_valid[e], tbl_hop[e]);
                                if (e >= N_FIXED) begin
                                        tbl_gnt[e][o] = g;
                                end
                        end
                end
        endtask

        task automatic check_cycle(input port_vec_t [NP-1:0] gnt);
                check_grant("out_valid_o", exp_valid, out_valid);
                for (int o = 0; o < NP; o++) begin
                        check_grant($sformatf("out_grant_o[%0d]", o), gnt[o], out_grant[o]);
                        check_flit($sformatf("out_flit_o[%0d]", o), exp_flit[o], out_flit[o]);
                end
        endtask

        // what the outputs show one cycle after row e
        task automatic update_expect(input int e);
                for (int o = 0; o < NP; o++) begin
                        exp_valid[o] = |tbl_gnt[e][o];
                        for (int i = 0; i < NP; i++) begin
                                if (tbl_gnt[e][o][i]) begin
                                        exp_flit[o] = tbl_flit[e][i];
                                end
                        end
                end
        endtask

        initial begin
                arst_n    = 1'b0;
                in_valid  = '0;
                nexthop   = '0;
                flit_in   = '0;
                exp_valid = '0;
                exp_flit  = '0;
                seed_ret  = $urandom(32'h3102d1ac);
                build_table();

                repeat (3) @(posedge clk);
                arst_n <= 1'b1;
                @(negedge clk);
                check_cycle('0);                        // reset state, no requests

                for (int e = 0; e < TBL_LEN; e++) begin
                        @(posedge clk);
                        in_valid <= tbl_valid[e];
                        nexthop  <= tbl_hop[e];
                        flit_in  <= tbl_flit[e];
                        @(negedge clk);
                        check_cycle(tbl_gnt[e]);
                        update_expect(e);
                end

                // drain last row
                @(posedge clk);
                in_valid <= '0;
                @(negedge clk);
                check_cycle('0);

                $display("Test completed successfully");
                $finish;
        end

endmodule

// ==== switch_alloc_top.sv ====
`include "noc_defs.svh"

module switch_alloc_top (
        input  logic                                    clk,
        input  logic                                    arst_n_i,
        input  noc_dir_pkg::port_vec_t                  in_valid_i,
        input  noc_dir_pkg::dir_t [`NUM_PORTS-1:0]      nexthop_i,
        input  noc_flit_pkg::flit_t [`NUM_PORTS-1:0]    flit_i,
        output noc_dir_pkg::port_vec_t [`NUM_PORTS-1:0] out_grant_o,  // back to input side
        output noc_dir_pkg::port_vec_t                  out_valid_o,
        output noc_flit_pkg::flit_t [`NUM_PORTS-1:0]    out_flit_o
);
        import noc_dir_pkg::*;

        // one arbiter per output
        rr_processor #(
                .OUT_DIR    (DIR_N)
        ) u_rr_n (
                .clk        (clk),
                .arst_n_i   (arst_n_i),
                .in_valid_i (in_valid_i),
                .nexthop_i  (nexthop_i),
                .grant_o    (out_grant_o[DIR_N])
        );

        rr_processor #(
                .OUT_DIR    (DIR_S)
        ) u_rr_s (
                .clk        (clk),
                .arst_n_i   (arst_n_i),
                .in_valid_i (in_valid_i),
                .nexthop_i  (nexthop_i),
                .grant_o    (out_grant_o[DIR_S])
        );

        rr_processor #(
                .OUT_DIR    (DIR_W)
        ) u_rr_w (
                .clk        (clk),
                .arst_n_i   (arst_n_i),
                .in_valid_i (in_valid_i),
                .nexthop_i  (nexthop_i),
                .grant_o    (out_grant_o[DIR_W])
        );

        rr_processor #(
                .OUT_DIR    (DIR_E)
        ) u_rr_e (
                .clk        (clk),
                .arst_n_i   (arst_n_i),
                .in_valid_i (in_valid_i),
                .nexthop_i  (nexthop_i),
                .grant_o    (out_grant_o[DIR_E])
        );

        rr_processor #(
                .OUT_DIR    (DIR_L)
        ) u_rr_l (
                .clk        (clk),
                .arst_n_i   (arst_n_i),
                .in_valid_i (in_valid_i),
                .nexthop_i  (nexthop_i),
                .grant_o    (out_grant_o[DIR_L])
        );

        // flits land on outputs one cycle after their grant
        flit_crossbar u_flit_crossbar (
                .clk         (clk),
                .arst_n_i    (arst_n_i),
                .grant_i     (out_grant_o),
                .flit_i      (flit_i),
                .out_valid_o (out_valid_o),
                .out_flit_o  (out_flit_o)
        );

endmodule
